/* hw/int_core_pkg.sv */
package int_core_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int XLEN      = 32;
    localparam int PRF_IDX_W = 6;
    localparam int PRF_DEPTH = 1 << PRF_IDX_W;
    localparam int ROB_ID_W  = 5;
    localparam int CDB_WIDTH = 2;

    // Bus slot owners
    localparam int CDB_EXT_SLOT = 0;
    localparam int CDB_ALU_SLOT = 1;

    //////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

    //////////////////////////////////////////////////
    // Packets
    //////////////////////////////////////////////////

    // Renamed micro-op from dispatch
    typedef struct packed {
        logic [ROB_ID_W-1:0]  rob_id;
        logic [PRF_IDX_W-1:0] rs1_phy;
        logic                 rs1_ready;
        logic [PRF_IDX_W-1:0] rs2_phy;
        logic                 rs2_ready;
        logic [PRF_IDX_W-1:0] rd_phy;
        logic                 op2_imm;
        logic [XLEN-1:0]      imm;
        alu_op_t              fu_opcode;
    } dispatch_uop_t;

    // Station slot contents, ready bits move with wakeup
    typedef struct packed {
        logic [ROB_ID_W-1:0]  rob_id;
        logic [PRF_IDX_W-1:0] rs1_phy;
        logic                 rs1_ready;
        logic [PRF_IDX_W-1:0] rs2_phy;
        logic                 rs2_ready;
        logic [PRF_IDX_W-1:0] rd_phy;
        logic                 op2_imm;
        logic [XLEN-1:0]      imm;
        alu_op_t              fu_opcode;
    } rs_entry_t;

    typedef struct packed {
        logic [ROB_ID_W-1:0]  rob_id;
        logic [PRF_IDX_W-1:0] rd_phy;
        alu_op_t              fu_opcode;
        logic                 op2_imm;
        logic [XLEN-1:0]      imm;
        logic [XLEN-1:0]      rs1_value;
        logic [XLEN-1:0]      rs2_value;
    } alu_issue_t;

    typedef struct packed {
        logic                 valid;
        logic [ROB_ID_W-1:0]  rob_id;
        logic [PRF_IDX_W-1:0] rd_phy;
        logic [XLEN-1:0]      value;
    } cdb_pkt_t;

endpackage

/* hw/rs_entry.sv */
module rs_entry (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 push_en,
    input  int_core_pkg::rs_entry_t                              entry_in,
    input  logic                                                 grant,
    input  int_core_pkg::cdb_pkt_t [int_core_pkg::CDB_WIDTH-1:0] cdb,
    output logic                                                 valid,
    output logic                                                 request,
    output int_core_pkg::rs_entry_t                              entry
);

    // True when any valid bus slot carries this tag
    function automatic logic tag_hit(
        input logic [int_core_pkg::PRF_IDX_W-1:0]                 tag,
        input int_core_pkg::cdb_pkt_t [int_core_pkg::CDB_WIDTH-1:0] bus
    );
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < int_core_pkg::CDB_WIDTH; s++) begin
            if (bus[s].valid && (bus[s].rd_phy == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    int_core_pkg::rs_entry_t entry_next;

    //////////////////////////////////////////////////
    // Next contents
    //////////////////////////////////////////////////

    always_comb begin
        entry_next = entry;
        if (push_en) begin
            // Same-cycle broadcast must not slip past a fresh micro-op
            entry_next           = entry_in;
            entry_next.rs1_ready = entry_in.rs1_ready | tag_hit(entry_in.rs1_phy, cdb);
            entry_next.rs2_ready = entry_in.rs2_ready | tag_hit(entry_in.rs2_phy, cdb);
        end else if (valid) begin
            if (tag_hit(entry.rs1_phy, cdb)) begin
                entry_next.rs1_ready = 1'b1;
            end
            if (tag_hit(entry.rs2_phy, cdb)) begin
                entry_next.rs2_ready = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        entry <= entry_next;
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (push_en) begin
            valid <= 1'b1;
        end else if (grant) begin
            valid <= 1'b0;
        end
    end

    // Immediate stands in for operand 2
    assign request = valid && entry.rs1_ready && (entry.rs2_ready || entry.op2_imm);

endmodule

/* hw/int_rs.sv */
module int_rs #(
    parameter int RS_DEPTH       = 4,
    parameter int DISPATCH_WIDTH = 2
) (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic [DISPATCH_WIDTH-1:0]                             dispatch_valid,
    input  int_core_pkg::dispatch_uop_t [DISPATCH_WIDTH-1:0]      dispatch_uop,
    input  int_core_pkg::cdb_pkt_t [int_core_pkg::CDB_WIDTH-1:0]  cdb,
    input  logic [int_core_pkg::XLEN-1:0]                         rs1_value,
    input  logic [int_core_pkg::XLEN-1:0]                         rs2_value,
    output logic                                                  dispatch_ready,
    output logic [int_core_pkg::PRF_IDX_W-1:0]                    rs1_phy,
    output logic [int_core_pkg::PRF_IDX_W-1:0]                    rs2_phy,
    output logic                                                  issue_valid,
    output int_core_pkg::alu_issue_t                              issue
);

    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    logic [RS_DEPTH-1:0]                        entry_valid;
    logic [RS_DEPTH-1:0]                        entry_request;
    logic [RS_DEPTH-1:0]                        entry_grant;
    logic [RS_DEPTH-1:0]                        entry_push_en;
    int_core_pkg::rs_entry_t [RS_DEPTH-1:0]     entry_array;
    int_core_pkg::rs_entry_t [RS_DEPTH-1:0]     entry_in;
    int_core_pkg::rs_entry_t [DISPATCH_WIDTH-1:0] dispatch_entry;
    int_core_pkg::rs_entry_t                    issued_entry;
    logic [RS_DEPTH-1:0][DISPATCH_WIDTH-1:0]    push_sel;
    logic [RS_DEPTH-1:0]                        taken;
    logic                                       claimed;
    logic [CNT_W-1:0]                           free_count;

    //////////////////////////////////////////////////
    // Entries
    //////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < DISPATCH_WIDTH; w++) begin
            dispatch_entry[w].rob_id    = dispatch_uop[w].rob_id;
            dispatch_entry[w].rs1_phy   = dispatch_uop[w].rs1_phy;
            dispatch_entry[w].rs1_ready = dispatch_uop[w].rs1_ready;
            dispatch_entry[w].rs2_phy   = dispatch_uop[w].rs2_phy;
            dispatch_entry[w].rs2_ready = dispatch_uop[w].rs2_ready;
            dispatch_entry[w].rd_phy    = dispatch_uop[w].rd_phy;
            dispatch_entry[w].op2_imm   = dispatch_uop[w].op2_imm;
            dispatch_entry[w].imm       = dispatch_uop[w].imm;
            dispatch_entry[w].fu_opcode = dispatch_uop[w].fu_opcode;
        end
    end

    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_entry
        rs_entry u_rs_entry (
            .clk      (clk),
            .reset    (reset),
            .push_en  (entry_push_en[i]),
            .entry_in (entry_in[i]),
            .grant    (entry_grant[i]),
            .cdb      (cdb),
            .valid    (entry_valid[i]),
            .request  (entry_request[i]),
            .entry    (entry_array[i])
        );
    end

    //////////////////////////////////////////////////
    // Allocation
    //////////////////////////////////////////////////

    // Each dispatch slot takes the lowest free entry left over
    always_comb begin
        push_sel = '0;
        taken    = '0;
        claimed  = 1'b0;
        for (int w = 0; w < DISPATCH_WIDTH; w++) begin
            claimed = 1'b0;
            if (dispatch_valid[w] && dispatch_ready) begin
                for (int i = 0; i < RS_DEPTH; i++) begin
                    if (!entry_valid[i] && !taken[i] && !claimed) begin
                        push_sel[i][w] = 1'b1;
                        taken[i]       = 1'b1;
                        claimed        = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            entry_push_en[i] = |push_sel[i];
            entry_in[i]      = '0;
            for (int w = 0; w < DISPATCH_WIDTH; w++) begin
                if (push_sel[i][w]) begin
                    entry_in[i] = dispatch_entry[w];
                end
            end
        end
    end

    // Room for a full dispatch group
    always_comb begin
        free_count = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!entry_valid[i]) begin
                free_count = free_count + CNT_W'(1);
            end
        end
    end

    assign dispatch_ready = (free_count >= CNT_W'(DISPATCH_WIDTH));

    //////////////////////////////////////////////////
    // Select and issue
    //////////////////////////////////////////////////

    // Isolate lowest set request bit
    assign entry_grant = entry_request & (~entry_request + RS_DEPTH'(1));
    assign issue_valid = |entry_grant;

    always_comb begin
        issued_entry = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (entry_grant[i]) begin
                issued_entry = entry_array[i];
            end
        end
    end

    assign rs1_phy = issued_entry.rs1_phy;
    assign rs2_phy = issued_entry.rs2_phy;

    always_comb begin
        issue.rob_id    = issued_entry.rob_id;
        issue.rd_phy    = issued_entry.rd_phy;
        issue.fu_opcode = issued_entry.fu_opcode;
        issue.op2_imm   = issued_entry.op2_imm;
        issue.imm       = issued_entry.imm;
        issue.rs1_value = rs1_value;
        issue.rs2_value = rs2_value;
    end

endmodule

/* hw/phys_regfile.sv */
module phys_regfile (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  int_core_pkg::cdb_pkt_t [int_core_pkg::CDB_WIDTH-1:0] cdb,
    input  logic [int_core_pkg::PRF_IDX_W-1:0]                   rs1_phy,
    input  logic [int_core_pkg::PRF_IDX_W-1:0]                   rs2_phy,
    output logic [int_core_pkg::XLEN-1:0]                        rs1_value,
    output logic [int_core_pkg::XLEN-1:0]                        rs2_value
);

    logic [int_core_pkg::XLEN-1:0] regs [int_core_pkg::PRF_DEPTH];

    //////////////////////////////////////////////////
    // Write ports, one per bus slot
    //////////////////////////////////////////////////

    // Slots never share a destination in one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < int_core_pkg::PRF_DEPTH; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int s = 0; s < int_core_pkg::CDB_WIDTH; s++) begin
                if (cdb[s].valid) begin
                    regs[cdb[s].rd_phy] <= cdb[s].value;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // Wakeup and write share an edge, so no bypass here
    assign rs1_value = regs[rs1_phy];
    assign rs2_value = regs[rs2_phy];

endmodule

/* hw/fu_alu.sv */
module fu_alu (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     issue_valid,
    input  int_core_pkg::alu_issue_t issue,
    output int_core_pkg::cdb_pkt_t   result
);

    logic [int_core_pkg::XLEN-1:0]      op1;
    logic [int_core_pkg::XLEN-1:0]      op2;
    logic [4:0]                         shamt;
    logic                               less_than;
    logic [int_core_pkg::XLEN-1:0]      alu_out;

    logic                               res_valid;
    logic [int_core_pkg::ROB_ID_W-1:0]  res_rob_id;
    logic [int_core_pkg::PRF_IDX_W-1:0] res_rd_phy;
    logic [int_core_pkg::XLEN-1:0]      res_value;

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    assign op1       = issue.rs1_value;
    assign op2       = issue.op2_imm ? issue.imm : issue.rs2_value;
    assign shamt     = op2[4:0];
    assign less_than = $signed(op1) < $signed(op2);

    always_comb begin
        unique case (issue.fu_opcode)
            int_core_pkg::ALU_ADD: alu_out = op1 + op2;
            int_core_pkg::ALU_SUB: alu_out = op1 - op2;
            int_core_pkg::ALU_AND: alu_out = op1 & op2;
            int_core_pkg::ALU_OR:  alu_out = op1 | op2;
            int_core_pkg::ALU_XOR: alu_out = op1 ^ op2;
            int_core_pkg::ALU_SLL: alu_out = op1 << shamt;
            int_core_pkg::ALU_SRL: alu_out = op1 >> shamt;
            int_core_pkg::ALU_SLT: alu_out = {{(int_core_pkg::XLEN-1){1'b0}}, less_than};
            default:               alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue_valid;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        res_rob_id <= issue.rob_id;
        res_rd_phy <= issue.rd_phy;
        res_value  <= alu_out;
    end

    always_comb begin
        result.valid  = res_valid;
        result.rob_id = res_rob_id;
        result.rd_phy = res_rd_phy;
        result.value  = res_value;
    end

endmodule

/* hw/int_issue_slice.sv */
module int_issue_slice #(
    parameter int RS_DEPTH       = 4,
    parameter int DISPATCH_WIDTH = 2
) (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic [DISPATCH_WIDTH-1:0]                        dispatch_valid,
    input  int_core_pkg::dispatch_uop_t [DISPATCH_WIDTH-1:0] dispatch_uop,
    input  int_core_pkg::cdb_pkt_t                           ext_cdb,
    output logic                                             dispatch_ready,
    output int_core_pkg::cdb_pkt_t                           cdb_out
);

    int_core_pkg::cdb_pkt_t [int_core_pkg::CDB_WIDTH-1:0] cdb;
    int_core_pkg::cdb_pkt_t                               alu_result;
    int_core_pkg::alu_issue_t                             issue;
    logic                                                 issue_valid;
    logic [int_core_pkg::PRF_IDX_W-1:0]                   rs1_phy;
    logic [int_core_pkg::PRF_IDX_W-1:0]                   rs2_phy;
    logic [int_core_pkg::XLEN-1:0]                        rs1_value;
    logic [int_core_pkg::XLEN-1:0]                        rs2_value;

    // Two-slot bus, external units then this ALU
    assign cdb[int_core_pkg::CDB_EXT_SLOT] = ext_cdb;
    assign cdb[int_core_pkg::CDB_ALU_SLOT] = alu_result;
    assign cdb_out                         = alu_result;

    int_rs #(
        .RS_DEPTH       (RS_DEPTH),
        .DISPATCH_WIDTH (DISPATCH_WIDTH)
    ) u_int_rs (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .cdb            (cdb),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .dispatch_ready (dispatch_ready),
        .rs1_phy        (rs1_phy),
        .rs2_phy        (rs2_phy),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

    phys_regfile u_phys_regfile (
        .clk       (clk),
        .reset     (reset),
        .cdb       (cdb),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    fu_alu u_fu_alu (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .result      (alu_result)
    );

endmodule

/* verification/int_issue_slice_chk.sv */
module int_issue_slice_chk #(
    parameter int RS_DEPTH = 4
) (
    input logic                clk,
    input logic                reset,
    input logic [RS_DEPTH-1:0] entry_grant,
    input logic [RS_DEPTH-1:0] entry_push_en,
    input logic [RS_DEPTH-1:0] entry_valid,
    input logic [RS_DEPTH-1:0] entry_request,
    input logic                dispatch_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // Granted slot is empty at the next edge
    grant_frees_entry: assert property (@(posedge clk) disable iff (reset)
        (|entry_grant) |=> ((entry_valid & $past(entry_grant)) == '0))
        else $error("granted entry still valid one cycle later");

    // Pushed slot holds a micro-op at the next edge
    push_fills_entry: assert property (@(posedge clk) disable iff (reset)
        (|entry_push_en) |=> ((entry_valid & $past(entry_push_en)) == $past(entry_push_en)))
        else $error("pushed entry not valid one cycle later");

    // First edge with reset low
    ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> dispatch_ready)
        else $error("dispatch_ready low right after reset");

    // Ready bits only ever set, so a waiting requester keeps asking
    request_held: assert property (@(posedge clk) disable iff (reset)
        ((entry_request & ~entry_grant) != '0) |=>
        (($past(entry_request & ~entry_grant) & ~entry_request) == '0))
        else $error("requesting entry dropped its request without a grant");

endmodule

bind int_rs int_issue_slice_chk #(
    .RS_DEPTH (RS_DEPTH)
) u_int_issue_slice_chk (
    .clk            (clk),
    .reset          (reset),
    .entry_grant    (entry_grant),
    .entry_push_en  (entry_push_en),
    .entry_valid    (entry_valid),
    .entry_request  (entry_request),
    .dispatch_ready (dispatch_ready)
);

/* verification/int_issue_slice_tb.sv */
module int_issue_slice_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RS_DEPTH       = 4;
    localparam int DISPATCH_WIDTH = 2;
    localparam int NUM_ROWS       = 11;
    localparam int MAX_FILL_PAIRS = 8;

    typedef struct {
        string                       name;
        logic                        ext_en;
        logic [5:0]                  ext_tag;
        logic [31:0]                 ext_val;
        int                          ext_delay;
        logic [1:0]                  uv;
        int_core_pkg::dispatch_uop_t u0;
        int_core_pkg::dispatch_uop_t u1;
        logic                        fill;
    } row_t;

    logic                                             clk;
    logic                                             reset;
    logic [DISPATCH_WIDTH-1:0]                        dispatch_valid;
    int_core_pkg::dispatch_uop_t [DISPATCH_WIDTH-1:0] dispatch_uop;
    int_core_pkg::cdb_pkt_t                           ext_cdb;
    logic                                             dispatch_ready;
    int_core_pkg::cdb_pkt_t                           cdb_out;

    row_t                        rows [NUM_ROWS];
    logic [31:0]                 shadow [64];
    int_core_pkg::dispatch_uop_t pend_uop [32];
    logic [31:0]                 pend_valid;
    logic [4:0]                  next_rob;
    int                          outstanding;
    int                          results_seen;
    string                       cur_name;
    logic [31:0]                 lfsr_state;

    int_issue_slice #(
        .RS_DEPTH       (RS_DEPTH),
        .DISPATCH_WIDTH (DISPATCH_WIDTH)
    ) u_int_issue_slice (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .ext_cdb        (ext_cdb),
        .dispatch_ready (dispatch_ready),
        .cdb_out        (cdb_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog sized from the table length
    initial begin
        #(NUM_ROWS * 30 * 100);
        $display("watchdog expired before the tests finished");
        stop_run();
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int k = 0; k < n; k++) begin
            b          = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
            r          = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] ref_alu(input int_core_pkg::alu_op_t op,
                                            input logic [31:0] a, input logic [31:0] b);
        case (op)
            int_core_pkg::ALU_ADD: return a + b;
            int_core_pkg::ALU_SUB: return a - b;
            int_core_pkg::ALU_AND: return a & b;
            int_core_pkg::ALU_OR:  return a | b;
            int_core_pkg::ALU_XOR: return a ^ b;
            int_core_pkg::ALU_SLL: return a << b[4:0];
            int_core_pkg::ALU_SRL: return a >> b[4:0];
            default:               return {31'd0, $signed(a) < $signed(b)};
        endcase
    endfunction

    function automatic int_core_pkg::dispatch_uop_t make_uop(
        input int_core_pkg::alu_op_t op, input logic [5:0] rs1, input logic r1_rdy,
        input logic [5:0] rs2, input logic r2_rdy, input logic [5:0] rd,
        input logic imm_en, input logic [31:0] imm);
        int_core_pkg::dispatch_uop_t u;
        u.rob_id    = '0;
        u.rs1_phy   = rs1;
        u.rs1_ready = r1_rdy;
        u.rs2_phy   = rs2;
        u.rs2_ready = r2_rdy;
        u.rd_phy    = rd;
        u.op2_imm   = imm_en;
        u.imm       = imm;
        u.fu_opcode = op;
        return u;
    endfunction

    function automatic row_t make_row(input string name, input logic ext_en,
        input logic [5:0] tag, input logic [31:0] val, input int delay, input logic [1:0] uv,
        input int_core_pkg::dispatch_uop_t u0, input int_core_pkg::dispatch_uop_t u1,
        input logic fill);
        row_t r;
        r.name      = name;
        r.ext_en    = ext_en;
        r.ext_tag   = tag;
        r.ext_val   = val;
        r.ext_delay = delay;
        r.uv        = uv;
        r.u0        = u0;
        r.u1        = u1;
        r.fill      = fill;
        return r;
    endfunction

    task automatic drive_ext(input logic [5:0] tag, input logic [31:0] val);
        ext_cdb.valid  <= 1'b1;
        ext_cdb.rob_id <= '0;
        ext_cdb.rd_phy <= tag;
        ext_cdb.value  <= val;
        shadow[tag] = val;
        @(posedge clk);
        ext_cdb.valid <= 1'b0;
    endtask

    // Drives at the current edge, returns at the accepting edge
    task automatic dispatch_pair(input int_core_pkg::dispatch_uop_t u0,
                                 input int_core_pkg::dispatch_uop_t u1,
                                 input logic [1:0] uv, output int waited);
        u0.rob_id = next_rob;
        u1.rob_id = next_rob + 5'd1;
        if (uv[0]) begin
            pend_uop[u0.rob_id]   = u0;
            pend_valid[u0.rob_id] = 1'b1;
            outstanding++;
        end
        if (uv[1]) begin
            pend_uop[u1.rob_id]   = u1;
            pend_valid[u1.rob_id] = 1'b1;
            outstanding++;
        end
        next_rob = next_rob + 5'd2;
        dispatch_valid <= uv;
        dispatch_uop   <= {u1, u0};
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!dispatch_ready);
    endtask

    //////////////////////////////////////////////////
    // Scoreboard
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        logic [4:0]                  id;
        int_core_pkg::dispatch_uop_t u;
        logic [31:0]                 exp;
        if (!reset && cdb_out.valid) begin
            id = cdb_out.rob_id;
            assert (pend_valid[id]) else begin
                $display("rob_id %0d returned while not outstanding in %s", id, cur_name);
                stop_run();
            end
            u   = pend_uop[id];
            exp = ref_alu(u.fu_opcode, shadow[u.rs1_phy],
                          u.op2_imm ? u.imm : shadow[u.rs2_phy]);
            assert (cdb_out.value == exp) else begin
                $display("error %s: expected %h, actual %h", cur_name, exp, cdb_out.value);
                stop_run();
            end
            assert (cdb_out.rd_phy == u.rd_phy) else begin
                $display("error %s: expected %h, actual %h", cur_name, u.rd_phy, cdb_out.rd_phy);
                stop_run();
            end
            shadow[u.rd_phy] = cdb_out.value;
            pend_valid[id]   = 1'b0;
            outstanding--;
            results_seen++;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        int_core_pkg::dispatch_uop_t nil;
        int_core_pkg::dispatch_uop_t ra;
        int_core_pkg::dispatch_uop_t rb;
        int                          waited;
        int                          seen0;
        int                          k;
        reset          = 1'b1;
        dispatch_valid = '0;
        dispatch_uop   = '0;
        ext_cdb        = '0;
        lfsr_state     = 32'ha816_6d8b;
        pend_valid     = '0;
        next_rob       = '0;
        outstanding    = 0;
        results_seen   = 0;
        cur_name       = "reset";
        nil            = '0;
        for (int r = 0; r < 64; r++) begin
            shadow[r] = '0;
        end

        rows[0] = make_row("preload_r1", 1, 6'd1, 32'h0000_00f0, 0, 2'b00, nil, nil, 0);
        rows[1] = make_row("preload_r2", 1, 6'd2, 32'hffff_fff3, 0, 2'b00, nil, nil, 0);
        rows[2] = make_row("add_sub", 0, 0, 0, 0, 2'b11,
            make_uop(int_core_pkg::ALU_ADD, 1, 1, 2, 1, 10, 0, 0),
            make_uop(int_core_pkg::ALU_SUB, 1, 1, 2, 1, 11, 0, 0), 0);
        rows[3] = make_row("and_or", 0, 0, 0, 0, 2'b11,
            make_uop(int_core_pkg::ALU_AND, 1, 1, 2, 1, 12, 0, 0),
            make_uop(int_core_pkg::ALU_OR, 1, 1, 2, 1, 13, 0, 0), 0);
        rows[4] = make_row("xor_sll", 0, 0, 0, 0, 2'b11,
            make_uop(int_core_pkg::ALU_XOR, 1, 1, 2, 1, 14, 0, 0),
            make_uop(int_core_pkg::ALU_SLL, 1, 1, 2, 1, 15, 0, 0), 0);
        rows[5] = make_row("srl_slt", 0, 0, 0, 0, 2'b11,
            make_uop(int_core_pkg::ALU_SRL, 2, 1, 1, 1, 16, 0, 0),
            make_uop(int_core_pkg::ALU_SLT, 2, 1, 1, 1, 17, 0, 0), 0);
        rows[6] = make_row("imm_add_sll", 0, 0, 0, 0, 2'b11,
            make_uop(int_core_pkg::ALU_ADD, 1, 1, 0, 0, 18, 1, 32'hffff_fffb),
            make_uop(int_core_pkg::ALU_SLL, 1, 1, 0, 0, 19, 1, 32'd4), 0);
        rows[7] = make_row("imm_srl_slt", 0, 0, 0, 0, 2'b11,
            make_uop(int_core_pkg::ALU_SRL, 2, 1, 0, 0, 20, 1, 32'd3),
            make_uop(int_core_pkg::ALU_SLT, 1, 1, 0, 0, 21, 1, 32'hffff_ffff), 0);
        rows[8] = make_row("ext_wakeup", 1, 6'd3, 32'h0000_0055, 4, 2'b01,
            make_uop(int_core_pkg::ALU_ADD, 3, 0, 1, 1, 22, 0, 0), nil, 0);
        // Second op waits on the first one's destination
        rows[9] = make_row("chain", 0, 0, 0, 0, 2'b11,
            make_uop(int_core_pkg::ALU_ADD, 1, 1, 2, 1, 23, 0, 0),
            make_uop(int_core_pkg::ALU_XOR, 23, 0, 1, 1, 24, 0, 0), 0);
        rows[10] = make_row("fill", 0, 0, 0, 0, 2'b00, nil, nil, 1);

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        assert (!cdb_out.valid && dispatch_ready) else begin
            $display("outputs not in reset state after reset release");
            stop_run();
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            cur_name = rows[i].name;
            if (rows[i].fill) begin
                k = 0;
                waited = 1;
                while (k < MAX_FILL_PAIRS && waited == 1) begin
                    ra = make_uop(int_core_pkg::alu_op_t'(rand_bits(3)),
                        rand_bits(1) ? 6'd2 : 6'd1, 1, rand_bits(1) ? 6'd2 : 6'd1, 1,
                        6'(32 + 2 * k), rand_bits(1), rand_bits(32));
                    rb = make_uop(int_core_pkg::alu_op_t'(rand_bits(3)),
                        rand_bits(1) ? 6'd2 : 6'd1, 1, rand_bits(1) ? 6'd2 : 6'd1, 1,
                        6'(33 + 2 * k), rand_bits(1), rand_bits(32));
                    dispatch_pair(ra, rb, 2'b11, waited);
                    k++;
                end
                dispatch_valid <= '0;
                assert (waited > 1) else begin
                    $display("station never filled, dispatch_ready stayed high");
                    stop_run();
                end
            end else begin
                if (rows[i].ext_en && rows[i].ext_delay == 0) begin
                    drive_ext(rows[i].ext_tag, rows[i].ext_val);
                end
                if (rows[i].uv != 2'b00) begin
                    dispatch_pair(rows[i].u0, rows[i].u1, rows[i].uv, waited);
                    dispatch_valid <= '0;
                end
                if (rows[i].ext_en && rows[i].ext_delay > 0) begin
                    seen0 = results_seen;
                    repeat (rows[i].ext_delay) @(posedge clk);
                    assert (results_seen == seen0) else begin
                        $display("result appeared before its source was broadcast");
                        stop_run();
                    end
                    drive_ext(rows[i].ext_tag, rows[i].ext_val);
                end
            end
            wait (outstanding == 0);
            @(posedge clk);
        end

        repeat (2) @(posedge clk);
        if (dispatch_ready && !cdb_out.valid) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("station did not drain at the end of the run");
            stop_run();
        end
    end

endmodule

/* int_issue_slice.f */
hw/int_core_pkg.sv
hw/rs_entry.sv
hw/int_rs.sv
hw/phys_regfile.sv
hw/fu_alu.sv
hw/int_issue_slice.sv
verification/int_issue_slice_chk.sv
verification/int_issue_slice_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the issue slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module int_issue_slice_tb \
    -f int_issue_slice.f \
    -o int_issue_slice_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/int_issue_slice_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

exit 0
